//--- pauseMenuTop.f
menuPkg.sv
buttonConditioner.sv
menuApbRegs.sv
menuSelector.sv
menuGlyphRenderer.sv
pixelScanner.sv
pauseMenuTop.sv
pauseMenu_properties.sv
tbPauseMenu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tbPauseMenu
FILELIST  ?= pauseMenuTop.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported an error"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tbPauseMenu.sv
`timescale 1ns/1ns

module tbPauseMenu;

    import menuPkg::*;

    typedef struct packed {
        menuModeT    mode;
        logic [11:0] btnSeq;     // 2-bit press codes, first press in the low bits
        logic        stall;      // random pixelReady while grabbing
        logic [1:0]  expSel;
        logic [1:0]  expChoice;
        logic        expValid;
        logic        expBox1;    // 1 means white
        logic        expBox2;
        logic        expTitle;
    } rowT;

    localparam int NUM_ROWS      = 14;
    localparam int FRAME_BEATS   = 6144;
    localparam int BOX1_IDX      = 6104;   // rawX 56, rawY 63
    localparam int BOX2_IDX      = 6119;   // rawX 71, rawY 63
    localparam int TITLE_IDX     = 5682;   // rawX 18, rawY 59, inside the G
    localparam int FRAME_TIMEOUT = 20000;
    localparam int APB_TIMEOUT   = 16;
    localparam int STATUS_POLLS  = 40;

    logic      clk;
    logic      rstN;
    logic      btnL, btnR, btnC;
    logic      psel, penable, pwrite;
    apbAddrT   paddr;
    apbDataT   pwdata;
    apbDataT   prdata;
    logic      pready, pslverr, irq;
    logic      pixelValid, pixelReady, frameStart;
    oledPixelT pixelData;

    logic      stallMode;
    rowT       rows [NUM_ROWS];
    int        beatCount;
    int        whiteCount;
    oledPixelT box1Col, box2Col, titleCol;

    pauseMenuTop #(.DEBOUNCE_CYCLES(16'd4)) dut_i (
        .clk, .rstN, .btnL, .btnR, .btnC,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .irq, .pixelValid, .pixelReady, .pixelData, .frameStart
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // sink readiness, about 70 % high when stalling
    initial begin
        void'($urandom(32'h94d8abf9));
        pixelReady = 1'b1;
        forever begin
            @(posedge clk);
            pixelReady <= stallMode ? (($urandom % 100) < 70) : 1'b1;
        end
    end

    ////////////////////
    // helpers

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic apbAccess(input logic write, input apbAddrT addr, input apbDataT data,
                             output apbDataT rdata);
        int waitCnt;
        waitCnt = 0;
        @(posedge clk);
        psel    <= 1'b1;        // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waitCnt++;
            if (waitCnt > APB_TIMEOUT) begin
                abortRun("Fail: APB slave never raised pready");
            end
            @(negedge clk);
        end
        rdata = prdata;         // valid in the access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input apbDataT data);
        apbDataT unused;
        apbAccess(1'b1, addr, data, unused);
    endtask

    task automatic apbRead(input apbAddrT addr, output apbDataT data);
        apbAccess(1'b0, addr, '0, data);
    endtask

    // code 1 left, 2 right, 3 confirm
    task automatic pressButton(input logic [1:0] code);
        @(posedge clk);
        btnL <= (code == 2'd1);
        btnR <= (code == 2'd2);
        btnC <= (code == 2'd3);
        repeat (10) @(posedge clk);
        btnL <= 1'b0;
        btnR <= 1'b0;
        btnC <= 1'b0;
        repeat (10) @(posedge clk);
    endtask

    task automatic waitStatus(input logic [4:0] expStatus);
        apbDataT rd;
        int      polls;
        polls = 0;
        apbRead(ADDR_STATUS, rd);
        while (rd[4:0] !== expStatus && polls < STATUS_POLLS) begin
            polls++;
            apbRead(ADDR_STATUS, rd);
        end
        checkValue("prdata STATUS", rd, {27'd0, expStatus});
    endtask

    // one frame from a frameStart beat up to the next one
    task automatic grabFrame();
        int idx;
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (!(pixelValid && pixelReady && frameStart)) begin
            waitCnt++;
            if (waitCnt > FRAME_TIMEOUT) begin
                abortRun("Fail: no frameStart beat arrived in time");
            end
            @(negedge clk);
        end
        idx        = 0;
        whiteCount = 0;
        waitCnt    = 0;
        forever begin
            if (pixelValid && pixelReady) begin
                if (frameStart && idx != 0) begin
                    break;
                end
                if (idx == BOX1_IDX) box1Col = pixelData;
                if (idx == BOX2_IDX) box2Col = pixelData;
                if (idx == TITLE_IDX) titleCol = pixelData;
                if (pixelData == COLOR_WHITE) whiteCount++;
                idx++;
            end
            waitCnt++;
            if (waitCnt > FRAME_TIMEOUT) begin
                abortRun("Fail: frame did not end in time");
            end
            @(negedge clk);
        end
        beatCount = idx;
    endtask

    task automatic loadTable();
        // mode, presses, stall, sel, choice, valid, box1, box2, title
        rows[0]  = '{modeOff,       12'h000, 1'b0, selNone, selNone, 1'b0, 1'b0, 1'b0, 1'b0};
        rows[1]  = '{modePauseMenu, 12'h000, 1'b0, selNone, selNone, 1'b0, 1'b0, 1'b0, 1'b1};
        rows[2]  = '{modePauseMenu, 12'h002, 1'b0, selYes,  selNone, 1'b0, 1'b1, 1'b0, 1'b1};
        rows[3]  = '{modePauseMenu, 12'h02A, 1'b0, selNo,   selNone, 1'b0, 1'b0, 1'b1, 1'b1};
        rows[4]  = '{modePauseMenu, 12'h01A, 1'b0, selYes,  selNone, 1'b0, 1'b1, 1'b0, 1'b1};
        rows[5]  = '{modePauseMenu, 12'h001, 1'b0, selNone, selNone, 1'b0, 1'b0, 1'b0, 1'b1};
        rows[6]  = '{modePauseMenu, 12'h00E, 1'b0, selYes,  selYes,  1'b1, 1'b1, 1'b0, 1'b1};
        rows[7]  = '{modeOverMenu,  12'h03A, 1'b0, selNo,   selNo,   1'b1, 1'b0, 1'b1, 1'b0};
        rows[8]  = '{modeOverMenu,  12'h003, 1'b0, selNone, selNo,   1'b0, 1'b0, 1'b0, 1'b0};
        rows[9]  = '{modeOverMenu,  12'h16A, 1'b0, selNone, selNo,   1'b0, 1'b0, 1'b0, 1'b0};
        rows[10] = '{modePaused,    12'h00E, 1'b0, selNone, selNo,   1'b0, 1'b0, 1'b0, 1'b1};
        rows[11] = '{modePauseMenu, 12'h002, 1'b1, selYes,  selNo,   1'b0, 1'b1, 1'b0, 1'b1};
        rows[12] = '{modeOverMenu,  12'h00A, 1'b1, selNo,   selNo,   1'b0, 1'b0, 1'b1, 1'b0};
        rows[13] = '{modeOff,       12'h000, 1'b1, selNone, selNo,   1'b0, 1'b0, 1'b0, 1'b0};
    endtask

    ////////////////////
    // main sequence

    initial begin
        apbDataT    rd;
        rowT        r;
        logic [1:0] code;
        rstN      = 1'b0;
        btnL      = 1'b0;
        btnR      = 1'b0;
        btnC      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        stallMode = 1'b0;
        loadTable();
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        apbRead(ADDR_STATUS, rd);
        checkValue("prdata STATUS", rd, 32'h0);
        apbWrite(ADDR_CTRL, 32'h3);
        apbRead(ADDR_CTRL, rd);
        checkValue("prdata CTRL", rd, 32'h3);
        apbRead(4'hC, rd);                       // unmapped
        checkValue("prdata unmapped", rd, 32'h0);
        checkValue("pslverr", pslverr, 1'b0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            r         = rows[i];
            stallMode = r.stall;
            apbWrite(ADDR_CTRL, {30'd0, modeOff});   // forces sel back to none
            apbWrite(ADDR_CTRL, {30'd0, r.mode});
            for (int k = 0; k < 6; k++) begin
                code = r.btnSeq[2*k +: 2];
                if (code == 2'd0) begin
                    break;
                end
                pressButton(code);
            end
            waitStatus({r.expValid, r.expChoice, r.expSel});
            @(negedge clk);
            checkValue("irq", irq, r.expValid);

            grabFrame();    // frame in progress may mix old and new state
            grabFrame();
            checkValue("beatCount", beatCount, FRAME_BEATS);
            checkValue("anyWhite", whiteCount != 0, r.mode != modeOff);
            checkValue("box1 pixelData", box1Col, r.expBox1 ? COLOR_WHITE : COLOR_BLACK);
            checkValue("box2 pixelData", box2Col, r.expBox2 ? COLOR_WHITE : COLOR_BLACK);
            checkValue("title pixelData", titleCol, r.expTitle ? COLOR_WHITE : COLOR_BLACK);

            if (r.expValid) begin
                apbWrite(ADDR_IRQCLR, 32'h1);
                @(negedge clk);
                checkValue("irq after clear", irq, 1'b0);
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- pauseMenu_properties.sv
`timescale 1ns/1ns

module pauseMenuProperties (
    input logic               clk,
    input logic               rstN,
    input logic               pixelValid,
    input logic               pixelReady,
    input menuPkg::oledPixelT pixelData,
    input logic               frameStart,
    input logic               pready
);

    // stalled beat must hold its payload
    property holdWhileStalled;
        @(posedge clk) disable iff (!rstN)
            pixelValid && !pixelReady |=> $stable(pixelData) && $stable(frameStart);
    endproperty

    property validUntilTaken;
        @(posedge clk) disable iff (!rstN)
            pixelValid && !pixelReady |=> pixelValid;
    endproperty

    property noWaitStates;
        @(posedge clk) disable iff (!rstN) pready;
    endproperty

    assert property (holdWhileStalled) else $error("pixel payload changed during a stall");
    assert property (validUntilTaken) else $error("pixelValid dropped before the beat was taken");
    assert property (noWaitStates) else $error("pready went low");

endmodule

bind pauseMenuTop pauseMenuProperties props_i (
    .clk, .rstN, .pixelValid, .pixelReady, .pixelData, .frameStart, .pready
);

//--- pauseMenuTop.sv
`timescale 1ns/1ns

module pauseMenuTop #(
    parameter logic [15:0] DEBOUNCE_CYCLES = 16'd50000 // 2 ms at 25 MHz
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              btnL,
    input  logic              btnR,
    input  logic              btnC,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  menuPkg::apbAddrT  paddr,
    input  menuPkg::apbDataT  pwdata,
    output menuPkg::apbDataT  prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              irq,
    output logic              pixelValid,
    input  logic              pixelReady,
    output menuPkg::oledPixelT pixelData,
    output logic              frameStart
);

    import menuPkg::*;

    logic       pressL, pressR, pressC;
    menuModeT   mode;
    menuSelT    sel;
    menuSelT    choice;
    logic       choiceStrobe;
    pixelCoordT rawX, rawY;
    oledPixelT  pixelColor;

    buttonConditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) buttons_i (
        .clk, .rstN, .btnL, .btnR, .btnC, .pressL, .pressR, .pressC
    );

    menuApbRegs regs_i (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .sel, .choiceStrobe, .choice, .mode, .irq
    );

    menuSelector selector_i (
        .clk, .rstN, .mode, .pressL, .pressR, .pressC,
        .sel, .choiceStrobe, .choice
    );

    // combinational, answers in the cycle rawX/rawY are presented
    menuGlyphRenderer renderer_i (
        .rawX, .rawY, .mode, .sel, .pixelColor
    );

    pixelScanner scanner_i (
        .clk, .rstN, .rawX, .rawY, .pixelColor,
        .pixelValid, .pixelReady, .pixelData, .frameStart
    );

endmodule

//--- pixelScanner.sv
`timescale 1ns/1ns

module pixelScanner (
    input  logic               clk,
    input  logic               rstN,
    output menuPkg::pixelCoordT rawX,
    output menuPkg::pixelCoordT rawY,
    input  menuPkg::oledPixelT  pixelColor,
    output logic               pixelValid,
    input  logic               pixelReady,
    output menuPkg::oledPixelT  pixelData,
    output logic               frameStart
);

    import menuPkg::*;

    pixelCoordT colCnt;
    pixelCoordT rowCnt;
    logic       lastCol;
    logic       lastRow;
    logic       s1Valid;
    logic       s1First;   // stage 1 holds raster index 0
    logic       s1Load;
    logic       s2Load;

    // a stage loads when the one after it has room
    assign s2Load  = !pixelValid || pixelReady;
    assign s1Load  = !s1Valid || s2Load;
    assign lastCol = (colCnt == OLED_WIDTH - 7'd1);
    assign lastRow = (rowCnt == OLED_HEIGHT - 7'd1);

    ////////////////////
    // raster counter and stage 1

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            colCnt  <= '0;
            rowCnt  <= '0;
            s1Valid <= 1'b0;
            s1First <= 1'b0;
        end else if (s1Load) begin
            s1Valid <= 1'b1;
            s1First <= (colCnt == '0) && (rowCnt == '0);
            colCnt  <= lastCol ? '0 : colCnt + 7'd1;
            if (lastCol) begin
                rowCnt <= lastRow ? '0 : rowCnt + 7'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1Load) begin
            rawX <= colCnt;
            rawY <= rowCnt;
        end
    end

    ////////////////////
    // stage 2, colour from the renderer

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixelValid <= 1'b0;
            frameStart <= 1'b0;
        end else if (s2Load) begin
            pixelValid <= s1Valid;
            frameStart <= s1Valid && s1First;
        end
    end

    always_ff @(posedge clk) begin
        if (s2Load) begin
            pixelData <= pixelColor;
        end
    end

endmodule

//--- menuGlyphRenderer.sv
`timescale 1ns/1ns

module menuGlyphRenderer (
    input  menuPkg::pixelCoordT rawX,
    input  menuPkg::pixelCoordT rawY,
    input  menuPkg::menuModeT   mode,
    input  menuPkg::menuSelT    sel,
    output menuPkg::oledPixelT  pixelColor
);

    import menuPkg::*;

    pixelCoordT x;
    pixelCoordT y;
    logic       rowT, rowP, rowY, rowN;   // text bands
    logic       titlePause, titleOver, promptResume, promptRestart;
    logic       yesText, noText, arrow1, arrow2, box1, box2;
    logic       entryYes, entryNo;
    logic       lit;

    function automatic logic inRange(input pixelCoordT v, input int lo, input int hi);
        return (int'(v) >= lo) && (int'(v) <= hi);
    endfunction

    // right-pointing arrow centred on row yc
    function automatic logic arrowAt(input pixelCoordT px, input pixelCoordT py, input int yc);
        int dy;
        dy = int'(py) - yc;
        return (px == 21 && dy >= -2 && dy <= 2) || (px == 22 && (dy == -2 || dy == 2))
            || (px == 23 && (dy == -1 || dy == 1)) || (px == 24 && dy == 0);
    endfunction

    // panel is mounted rotated
    assign x = OLED_HEIGHT - 7'd1 - rawY;
    assign y = rawX;

    assign rowT = inRange(y, 17, 23);
    assign rowP = inRange(y, 41, 47);
    assign rowY = inRange(y, 57, 63);
    assign rowN = inRange(y, 72, 78);

    ////////////////////
    // titles

    assign titlePause =
          (x == 4 && inRange(y, 18, 23)) || ((y == 17 || y == 23) && inRange(x, 5, 6))   // G
        || ((y == 18 || y == 22) && x == 7) || (x == 8 && (y == 22 || y == 23))
        || (x == 13 && rowT) || (x == 9 && inRange(y, 20, 23)) || (inRange(x, 10, 14) && y == 20)
        || (x == 12 && y == 17) || (x == 11 && y == 18) || (x == 10 && y == 19)           // A
        || (rowT && (x == 15 || x == 19)) || (y == 18 && (x == 16 || x == 18))
        || (y == 19 && x == 17)                                                           // M
        || (rowT && x == 21) || (inRange(x, 22, 24) && (y == 17 || y == 20 || y == 23))   // E
        || (rowT && x == 28) || (inRange(x, 29, 30) && (y == 17 || y == 20))
        || (inRange(y, 18, 19) && x == 31)                                                // P
        || (x == 37 && rowT) || (x == 33 && inRange(y, 20, 23)) || (inRange(x, 33, 37) && y == 20)
        || (x == 36 && y == 17) || (x == 35 && y == 18) || (x == 34 && y == 19)           // A
        || (inRange(y, 17, 22) && (x == 39 || x == 42)) || (inRange(x, 40, 41) && y == 23)
        || ((y == 17 || y == 20 || y == 23) && inRange(x, 44, 47))
        || (inRange(y, 18, 19) && x == 44) || (inRange(y, 21, 22) && x == 47)             // S
        || (rowT && x == 49) || (inRange(x, 50, 52) && (y == 17 || y == 20 || y == 23))
        || (rowT && x == 54) || (inRange(x, 55, 56) && (y == 17 || y == 23))
        || (inRange(y, 18, 22) && x == 57);                                               // D

    assign titleOver =
          (x == 7 && inRange(y, 18, 23)) || ((y == 17 || y == 23) && inRange(x, 8, 9))
        || ((y == 18 || y == 22) && x == 10) || (x == 11 && (y == 22 || y == 23))
        || (x == 17 && rowT) || (x == 13 && inRange(y, 20, 23)) || (inRange(x, 13, 17) && y == 20)
        || (x == 16 && y == 17) || (x == 15 && y == 18) || (x == 14 && y == 19)
        || (rowT && (x == 19 || x == 23)) || (y == 18 && (x == 20 || x == 22))
        || (y == 19 && x == 21)
        || (rowT && x == 25) || (inRange(x, 25, 27) && (y == 17 || y == 20 || y == 23))
        || (inRange(y, 18, 22) && (x == 32 || x == 36)) || ((y == 17 || y == 23) && inRange(x, 33, 35))
        || (inRange(y, 17, 21) && (x == 38 || x == 42)) || (y == 22 && (x == 39 || x == 41))
        || (x == 40 && y == 23)                                                           // V
        || (rowT && x == 44) || (inRange(x, 45, 47) && (y == 17 || y == 20 || y == 23))
        || (rowT && x == 49) || ((y == 17 || y == 20) && inRange(x, 49, 51))
        || (inRange(y, 18, 19) && x == 51) || (x == 50 && y == 21) || (x == 51 && y == 22)
        || (x == 52 && y == 23)                                                           // R
        || (x == 55 && (y == 23 || inRange(y, 17, 21)));                                  // !

    ////////////////////
    // prompts

    assign promptResume =
          (rowP && x == 13) || ((y == 41 || y == 44) && inRange(x, 13, 15))
        || (inRange(y, 42, 43) && x == 15) || (x == 14 && y == 45) || (x == 15 && y == 46)
        || (x == 16 && y == 47)
        || (rowP && x == 18) || (inRange(x, 19, 21) && (y == 41 || y == 44 || y == 47))
        || ((y == 41 || y == 44 || y == 47) && inRange(x, 23, 26))
        || (inRange(y, 42, 43) && x == 23) || (inRange(y, 45, 46) && x == 26)
        || (inRange(y, 41, 46) && (x == 28 || x == 31)) || (inRange(x, 29, 30) && y == 47)
        || (rowP && (x == 33 || x == 37)) || (y == 42 && (x == 34 || x == 36)) || (y == 43 && x == 35)
        || (rowP && x == 39) || (inRange(x, 40, 42) && (y == 41 || y == 44 || y == 47))
        || (x == 47 && (inRange(y, 41, 42) || inRange(y, 44, 45)))                         // ?
        || (inRange(x, 48, 50) && (y == 41 || y == 44)) || (inRange(y, 42, 43) && x == 50);

    assign promptRestart =
          (rowP && x == 10) || ((y == 41 || y == 44) && inRange(x, 10, 12))
        || (inRange(y, 42, 43) && x == 12) || (x == 11 && y == 45) || (x == 12 && y == 46)
        || (x == 13 && y == 47)
        || (rowP && x == 15) || (inRange(x, 16, 18) && (y == 41 || y == 44 || y == 47))
        || ((y == 41 || y == 44 || y == 47) && inRange(x, 20, 23))
        || (inRange(y, 42, 43) && x == 20) || (inRange(y, 45, 46) && x == 23)
        || (inRange(x, 25, 29) && y == 41) || (rowP && x == 27)                           // T
        || (x == 35 && rowP) || (x == 31 && inRange(y, 44, 47)) || (inRange(x, 31, 35) && y == 44)
        || (x == 34 && y == 41) || (x == 33 && y == 42) || (x == 32 && y == 43)
        || (rowP && x == 37) || ((y == 41 || y == 44) && inRange(x, 37, 39))
        || (inRange(y, 42, 43) && x == 39) || (x == 38 && y == 45) || (x == 39 && y == 46)
        || (x == 40 && y == 47)
        || (inRange(x, 42, 46) && y == 41) || (rowP && x == 44)                           // T
        || (x == 50 && (inRange(y, 41, 42) || inRange(y, 44, 45) || y == 47))
        || (inRange(x, 51, 53) && (y == 41 || y == 44)) || (inRange(y, 42, 43) && x == 53);

    ////////////////////
    // entries and highlight

    assign yesText =
          (inRange(x, 27, 31) && y == 59) || (inRange(y, 57, 58) && (x == 27 || x == 31))
        || (inRange(y, 60, 63) && x == 29)
        || (rowY && x == 33) || (inRange(x, 34, 36) && (y == 57 || y == 60 || y == 63))
        || ((y == 57 || y == 60 || y == 63) && inRange(x, 38, 41))
        || (inRange(y, 58, 59) && x == 38) || (inRange(y, 61, 62) && x == 41);

    assign noText =
          (rowN && (x == 27 || x == 31)) || (x == 28 && y == 74) || (x == 29 && y == 75)
        || (x == 30 && y == 76)
        || (inRange(y, 73, 77) && (x == 33 || x == 37)) || ((y == 72 || y == 78) && inRange(x, 34, 36));

    assign arrow1 = arrowAt(x, y, 60);
    assign arrow2 = arrowAt(x, y, 75);

    // inverted entry: white band with the glyph cut out
    assign box1 = inRange(y, 55, 65) && !yesText && !arrow1;
    assign box2 = inRange(y, 70, 80) && !noText && !arrow2;

    assign entryYes = (sel == selYes) ? box1 : yesText;
    assign entryNo  = (sel == selNo) ? box2 : noText;

    always_comb begin
        case (mode)
            modePaused:    lit = titlePause;
            modePauseMenu: lit = titlePause || promptResume || entryYes || entryNo;
            modeOverMenu:  lit = titleOver || promptRestart || entryYes || entryNo;
            default:       lit = 1'b0;
        endcase
    end

    assign pixelColor = lit ? COLOR_WHITE : COLOR_BLACK;

endmodule

//--- menuSelector.sv
`timescale 1ns/1ns

module menuSelector (
    input  logic              clk,
    input  logic              rstN,
    input  menuPkg::menuModeT mode,
    input  logic              pressL,
    input  logic              pressR,
    input  logic              pressC,
    output menuPkg::menuSelT  sel,
    output logic              choiceStrobe,
    output menuPkg::menuSelT  choice
);

    import menuPkg::*;

    menuModeT modeQ;       // mode seen last cycle
    logic     modeChange;
    logic     menuActive;
    menuSelT  selNext;

    assign modeChange = (mode != modeQ);
    assign menuActive = (mode == modePauseMenu) || (mode == modeOverMenu);

    // clamped ordering none -> yes -> no, left has priority
    always_comb begin
        selNext = sel;
        if (modeChange) begin
            selNext = selNone;
        end else if (menuActive && pressL) begin
            case (sel)
                selYes:  selNext = selNone;
                selNo:   selNext = selYes;
                default: selNext = sel;
            endcase
        end else if (menuActive && pressR) begin
            case (sel)
                selNone: selNext = selYes;
                selYes:  selNext = selNo;
                default: selNext = sel;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modeQ        <= modeOff;
            sel          <= selNone;
            choiceStrobe <= 1'b0;
        end else begin
            modeQ        <= mode;
            sel          <= selNext;
            choiceStrobe <= menuActive && !modeChange && pressC && (sel != selNone);
        end
    end

    always_ff @(posedge clk) begin
        if (pressC) begin
            choice <= sel; // only sampled together with choiceStrobe
        end
    end

endmodule

//--- menuApbRegs.sv
`timescale 1ns/1ns

module menuApbRegs (
    input  logic              clk,
    input  logic              rstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  menuPkg::apbAddrT  paddr,
    input  menuPkg::apbDataT  pwdata,
    output menuPkg::apbDataT  prdata,
    output logic              pready,
    output logic              pslverr,
    input  menuPkg::menuSelT  sel,
    input  logic              choiceStrobe,
    input  menuPkg::menuSelT  choice,
    output menuPkg::menuModeT mode,
    output logic              irq
);

    import menuPkg::*;

    logic    accessPhase;
    logic    wrCtrl;
    logic    wrIrqClr;
    menuSelT choiceReg;    // last confirmed entry
    logic    choiceValid;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign accessPhase = psel && penable;
    assign wrCtrl      = accessPhase && pwrite && (paddr == ADDR_CTRL);
    assign wrIrqClr    = accessPhase && pwrite && (paddr == ADDR_IRQCLR) && pwdata[0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mode <= modeOff;
        end else if (wrCtrl) begin
            mode <= pwdata[1:0];
        end
    end

    ////////////////////
    // sticky choice

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            choiceReg   <= selNone;
            choiceValid <= 1'b0;
        end else if (choiceStrobe) begin   // strobe beats a clear in the same cycle
            choiceReg   <= choice;
            choiceValid <= 1'b1;
        end else if (wrIrqClr) begin
            choiceValid <= 1'b0;
        end
    end

    assign irq = choiceValid;

    // read mux, IRQCLR reads as zero
    always_comb begin
        case (paddr)
            ADDR_CTRL:   prdata = {30'd0, mode};
            ADDR_STATUS: prdata = {27'd0, choiceValid, choiceReg, sel};
            default:     prdata = '0;
        endcase
    end

endmodule

//--- buttonConditioner.sv
`timescale 1ns/1ns

module buttonConditioner #(
    parameter logic [15:0] DEBOUNCE_CYCLES = 16'd50000
) (
    input  logic clk,
    input  logic rstN,
    input  logic btnL,
    input  logic btnR,
    input  logic btnC,
    output logic pressL,
    output logic pressR,
    output logic pressC
);

    logic [2:0]  btnRaw;
    logic [2:0]  syncA;         // first metastability flop
    logic [2:0]  syncB;
    logic [2:0]  pressQ;
    logic [15:0] stableCnt [3];

    assign btnRaw = {btnC, btnR, btnL};

    // counter saturates at DEBOUNCE_CYCLES, so one pulse per press
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncA  <= '0;
            syncB  <= '0;
            pressQ <= '0;
            for (int i = 0; i < 3; i++) begin
                stableCnt[i] <= '0;
            end
        end else begin
            syncA <= btnRaw;
            syncB <= syncA;
            for (int i = 0; i < 3; i++) begin
                pressQ[i] <= 1'b0;
                if (!syncB[i]) begin
                    stableCnt[i] <= '0; // released, re-arm
                end else if (stableCnt[i] != DEBOUNCE_CYCLES) begin
                    stableCnt[i] <= stableCnt[i] + 16'd1;
                    pressQ[i]    <= (stableCnt[i] == DEBOUNCE_CYCLES - 16'd1);
                end
            end
        end
    end

    assign pressL = pressQ[0];
    assign pressR = pressQ[1];
    assign pressC = pressQ[2];

endmodule

//--- menuPkg.sv
package menuPkg;

    ////////////////////
    // pixel geometry

    typedef logic [6:0]  pixelCoordT;   // one raster or rotated coordinate
    typedef logic [12:0] pixelIndexT;   // rawY * 96 + rawX
    typedef logic [15:0] oledPixelT;    // RGB565

    localparam pixelCoordT OLED_WIDTH  = 7'd96;
    localparam pixelCoordT OLED_HEIGHT = 7'd64;

    localparam oledPixelT COLOR_WHITE = 16'hFFFF;
    localparam oledPixelT COLOR_BLACK = 16'h0000;

    ////////////////////
    // menu state

    typedef logic [1:0] menuModeT;

    localparam menuModeT modeOff       = 2'd0;
    localparam menuModeT modePaused    = 2'd1; // title only
    localparam menuModeT modePauseMenu = 2'd2; // resume prompt
    localparam menuModeT modeOverMenu  = 2'd3; // restart prompt

    typedef enum logic [1:0] {
        selNone = 2'd0,
        selYes  = 2'd1,
        selNo   = 2'd2
    } menuSelT;

    ////////////////////
    // APB register map

    typedef logic [3:0]  apbAddrT;
    typedef logic [31:0] apbDataT;

    localparam apbAddrT ADDR_CTRL   = 4'h0;
    localparam apbAddrT ADDR_STATUS = 4'h4;
    localparam apbAddrT ADDR_IRQCLR = 4'h8;

endpackage
